/* binMapper.sv */
`timescale 1ns/1ps

module binMapper #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   sampleValid,
    input  logic [sampleWidth-1:0] sample,
    input  logic                   fineMode,
    input  logic [sampleWidth-1:0] windowLow,
    input  logic                   busy,
    output logic                   binValid,
    output logic [binBits-1:0]     binIdx
);

    localparam int cShift = histPkg::coarseShift(sampleWidth, binBits);
    localparam int fShift = histPkg::fineShift(sampleWidth, binBits);

    // one extra msb acts as borrow flag for codes below the window
    logic [sampleWidth:0]   offsetFull;
    logic                   inWindow;
    logic                   accept;
    logic [binBits-1:0]     coarseBin;
    logic [binBits-1:0]     fineBin;

    always_comb begin
        offsetFull = {1'b0, sample} - {1'b0, windowLow};
        // window is one coarse bin wide
        // borrow and overflow bits must both be zero
        inWindow = (offsetFull[sampleWidth:cShift] == '0);
        coarseBin = sample[sampleWidth-1:cShift];
        fineBin = offsetFull[cShift-1:fShift];
        // scan owns the bank while busy, drop everything
        accept = sampleValid && !busy && (!fineMode || inWindow);
    end

    // strobe stage
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            binValid <= 1'b0;
        end else begin
            binValid <= accept;
        end
    end

    // index payload, only meaningful with binValid
    always_ff @(posedge clk) begin
        if (accept) begin
            binIdx <= fineMode ? fineBin : coarseBin;
        end
    end

endmodule

/* histPkg.sv */
package histPkg;

    // sample code width from the TDC front end
    parameter int sampleWidthDef = 10;

    // bin index width, 16 bins per pass
    parameter int binBitsDef = 4;

    // per-bin counter width, saturates at all ones
    parameter int countWidthDef = 8;

    // coarse pass bin width in codes is 2**coarseShift
    // coarse bin index is simply the top binBits of the code
    function automatic int coarseShift(
        input int sampleWidth,
        input int binBits
    );
        return sampleWidth - binBits;
    endfunction

    // fine pass splits one coarse bin into 2**binBits fine bins
    // so each fine bin spans 2**fineShift codes
    function automatic int fineShift(
        input int sampleWidth,
        input int binBits
    );
        return sampleWidth - 2 * binBits;
    endfunction

endpackage

/* histStimulus.txt */
# columns: tag code count, S = count samples of code, F = finish, B = finish with stray
# sample of code and a second finish during the scan, W = expected windowLow, R = result
# coarse cluster in 512..575
S 530 6
S 100 3
S 540 4
S 900 2
S 575 2
F
W 512
# fine peak at 532..535, codes 0 511 576 1023 lie outside the window
S 532 3
S 0 1
S 533 2
S 511 2
S 535 4
S 576 2
S 520 2
S 1023 1
S 560 3
F
R 534 9
# coarse tie between bins 2 and 9, then a fine tie between bins 3 and 13
S 150 5
S 600 5
S 300 2
F
W 128
S 140 4
S 170 2
S 180 4
F
R 142 4
# saturation in both passes
S 700 300
F
W 640
S 645 300
S 690 10
F
R 646 255
# next pass sees only its own counts
S 260 4
S 650 3
F
W 256
S 300 5
S 258 2
F
R 302 5
# strays during the scans are ignored
S 800 4
B 810
W 768
S 790 3
S 820 2
B 790
R 790 3

/* histogramBank.sv */
`timescale 1ns/1ps

module histogramBank #(
    parameter int binBits = 4,
    parameter int countWidth = 8
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  binValid,
    input  logic [binBits-1:0]    binIdx,
    input  logic                  rdEn,
    input  logic [binBits-1:0]    rdIdx,
    output logic [countWidth-1:0] rdCount
);

    localparam int numBins = 1 << binBits;

    logic [countWidth-1:0] binCount [numBins];

    // counters must start empty for the very first coarse pass
    // afterwards every scan clears what it reads
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numBins; i++) begin
                binCount[i] <= '0;
            end
        end else begin
            for (int i = 0; i < numBins; i++) begin
                if (rdEn && (rdIdx == binBits'(i))) begin
                    // read-and-clear has priority over increment
                    binCount[i] <= '0;
                end else if (binValid && (binIdx == binBits'(i))) begin
                    // hold at max instead of wrapping
                    if (binCount[i] != '1) begin
                        binCount[i] <= binCount[i] + 1'b1;
                    end
                end
            end
        end
    end

    // registered read port, count appears one cycle after rdEn
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdCount <= binCount[rdIdx];
        end
    end

endmodule

/* peakScanner.sv */
`timescale 1ns/1ps

module peakScanner #(
    parameter int binBits = 4,
    parameter int countWidth = 8
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  acqFinish,
    output logic                  rdEn,
    output logic [binBits-1:0]    rdIdx,
    input  logic [countWidth-1:0] rdCount,
    output logic                  busy,
    output logic                  peakValid,
    output logic [binBits-1:0]    peakBin,
    output logic [countWidth-1:0] peakCount
);

    localparam logic [binBits-1:0] lastIdx = '1;

    // compare stage follows the bank read latency by one cycle
    logic                  cmpValid;
    logic                  cmpLast;
    logic [binBits-1:0]    cmpIdx;
    logic [countWidth-1:0] maxCount;
    logic [binBits-1:0]    maxBin;
    logic                  takeNew;

    // read sequencer
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            busy <= 1'b0;
            rdEn <= 1'b0;
            rdIdx <= '0;
        end else begin
            if (acqFinish && !busy) begin
                // finish during a scan is ignored
                busy <= 1'b1;
                rdEn <= 1'b1;
                rdIdx <= '0;
            end else if (rdEn) begin
                if (rdIdx == lastIdx) begin
                    rdEn <= 1'b0;
                end else begin
                    rdIdx <= rdIdx + 1'b1;
                end
            end
            // busy drops together with peakValid
            if (cmpValid && cmpLast) begin
                busy <= 1'b0;
            end
        end
    end

    // pipeline flags for the returned count
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmpValid <= 1'b0;
            cmpLast <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            cmpValid <= rdEn;
            cmpLast <= rdEn && (rdIdx == lastIdx);
            peakValid <= cmpValid && cmpLast;
        end
    end

    // bin 0 seeds the maximum
    // strict greater-than keeps the lower index on a tie
    assign takeNew = (cmpIdx == '0) || (rdCount > maxCount);

    always_ff @(posedge clk) begin
        cmpIdx <= rdIdx;
        if (cmpValid && takeNew) begin
            maxCount <= rdCount;
            maxBin <= cmpIdx;
        end
    end

    // running max is final once the last compare is done
    assign peakBin = maxBin;
    assign peakCount = maxCount;

endmodule

/* runSim.sh */
#!/bin/sh
# build and run the histogram peak finder testbench with Verilator
# the run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --assert \
    --top-module tofHistTb \
    --Mdir "$buildDir" \
    -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/VtofHistTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Test failed" "$logFile"; then
    exit 1
fi
exit 0

/* tofHistTb.sv */
`timescale 1ns/1ps

module tofHistTb;

    localparam int sampleWidth = histPkg::sampleWidthDef;
    localparam int binBits = histPkg::binBitsDef;
    localparam int countWidth = histPkg::countWidthDef;
    // finish strobe to resultValid, fixed by the 16 bin scan
    localparam int resultLatency = 19;
    // busy stays high for 16 reads plus the last compare
    localparam int busyCycles = 17;

    logic                   clk;
    logic                   arstN;
    logic                   sampleValid;
    logic [sampleWidth-1:0] sample;
    logic                   acqFinish;
    logic                   busy;
    logic                   fineMode;
    logic [sampleWidth-1:0] windowLow;
    logic                   resultValid;
    logic [sampleWidth-1:0] resultCode;
    logic [countWidth-1:0]  resultCount;

    // parsed records, tag plus two numbers
    byte recTag [$];
    int  recA [$];
    int  recB [$];

    int cycleCount = 0;
    int cycleLimit = 0;
    int finishCycle = 0;
    int resultCycle = 0;
    bit resultSeen = 1'b0;
    logic [sampleWidth-1:0] seenCode;
    logic [countWidth-1:0]  seenCount;
    int valueErrors = 0;
    int otherErrors = 0;

    tofHistTop #(
        .sampleWidth(sampleWidth),
        .binBits(binBits),
        .countWidth(countWidth)
    ) dut0 (
        .clk(clk),
        .arstN(arstN),
        .sampleValid(sampleValid),
        .sample(sample),
        .acqFinish(acqFinish),
        .busy(busy),
        .fineMode(fineMode),
        .windowLow(windowLow),
        .resultValid(resultValid),
        .resultCode(resultCode),
        .resultCount(resultCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // result strobe capture
    // values before the edge are the ones of the strobe cycle
    always @(posedge clk) begin
        if (resultValid) begin
            resultSeen = 1'b1;
            resultCycle = cycleCount;
            seenCode = resultCode;
            seenCount = resultCount;
        end
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic loadStimulus(output int nSamples, output int nFinish);
        int fd;
        string line;
        byte tag;
        int a;
        int b;
        nSamples = 0;
        nFinish = 0;
        fd = $fopen("histStimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open histStimulus.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            a = 0;
            b = 0;
            void'($sscanf(line, "%c %d %d", tag, a, b));
            recTag.push_back(tag);
            recA.push_back(a);
            recB.push_back(b);
            if (tag == "S") begin
                nSamples += b;
            end
            if (tag == "F" || tag == "B") begin
                nFinish++;
            end
        end
        $fclose(fd);
    endtask

    // every task starts and ends 5 ns after a rising edge
    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic driveSamples(input int code, input int count);
        int gap;
        for (int i = 0; i < count; i++) begin
            sampleValid = 1'b1;
            sample = sampleWidth'(code);
            @(posedge clk);
            #5;
            sampleValid = 1'b0;
            // 0 to 3 idle cycles
            gap = $urandom % 4;
            idleCycles(gap);
        end
    endtask

    // jam puts a stray sample and a second finish into the scan
    task automatic runFinish(input bit jam, input int jamCode);
        bit expBusy;
        // keep 2 cycles between last sample and finish
        idleCycles(2);
        acqFinish = 1'b1;
        resultSeen = 1'b0;
        finishCycle = cycleCount;
        @(posedge clk);
        #5;
        acqFinish = 1'b0;
        for (int c = 1; c < resultLatency + 1; c++) begin
            // scan runs from the cycle after the finish to the peak cycle
            expBusy = (c <= busyCycles);
            assert (busy == expBusy) else begin
                $display("error at %0t: busy expected %0b, actual %0b",
                         $time, expBusy, busy);
                valueErrors++;
            end
            if (jam && c == 4) begin
                sampleValid = 1'b1;
                sample = sampleWidth'(jamCode);
                acqFinish = 1'b1;
            end else begin
                sampleValid = 1'b0;
                acqFinish = 1'b0;
            end
            @(posedge clk);
            #5;
        end
    endtask

    task automatic checkWindow(input int expLow);
        assert (fineMode == 1'b1) else begin
            $display("error at %0t: fineMode expected 1, actual %0b", $time, fineMode);
            valueErrors++;
        end
        assert (windowLow == sampleWidth'(expLow)) else begin
            $display("error at %0t: windowLow expected %0d, actual %0d",
                     $time, expLow, windowLow);
            valueErrors++;
        end
        assert (!resultSeen) else begin
            $display("a result came out of a coarse pass, which should only set the window");
            otherErrors++;
        end
    endtask

    task automatic checkResult(input int expCode, input int expCount);
        assert (resultSeen) else begin
            $display("resultValid never came after the fine pass finish");
            otherErrors++;
        end
        if (resultSeen) begin
            assert (resultCycle - finishCycle == resultLatency) else begin
                $display("error at %0t: resultValid latency expected %0d, actual %0d",
                         $time, resultLatency, resultCycle - finishCycle);
                valueErrors++;
            end
            assert (seenCode == sampleWidth'(expCode)) else begin
                $display("error at %0t: resultCode expected %0d, actual %0d",
                         $time, expCode, seenCode);
                valueErrors++;
            end
            assert (seenCount == countWidth'(expCount)) else begin
                $display("error at %0t: resultCount expected %0d, actual %0d",
                         $time, expCount, seenCount);
                valueErrors++;
            end
        end
        assert (fineMode == 1'b0) else begin
            $display("error at %0t: fineMode expected 0, actual %0b", $time, fineMode);
            valueErrors++;
        end
    endtask

    initial begin
        int nSamples;
        int nFinish;
        void'($urandom(86));
        arstN = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        acqFinish = 1'b0;
        loadStimulus(nSamples, nFinish);
        cycleLimit = 4 * nSamples + 25 * nFinish + 20;
        repeat (2) @(posedge clk);
        #5;
        arstN = 1'b1;
        for (int i = 0; i < recTag.size(); i++) begin
            case (recTag[i])
                "S": driveSamples(recA[i], recB[i]);
                "F": runFinish(1'b0, 0);
                "B": runFinish(1'b1, recA[i]);
                "W": checkWindow(recA[i]);
                "R": checkResult(recA[i], recB[i]);
                default: begin
                    $display("stimulus record %0d has an unknown tag", i);
                    otherErrors++;
                end
            endcase
        end
        idleCycles(2);
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tofHistTop.sv */
`timescale 1ns/1ps

module tofHistTop #(
    parameter int sampleWidth = histPkg::sampleWidthDef,
    parameter int binBits = histPkg::binBitsDef,
    parameter int countWidth = histPkg::countWidthDef
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   sampleValid,
    input  logic [sampleWidth-1:0] sample,
    input  logic                   acqFinish,
    output logic                   busy,
    output logic                   fineMode,
    output logic [sampleWidth-1:0] windowLow,
    output logic                   resultValid,
    output logic [sampleWidth-1:0] resultCode,
    output logic [countWidth-1:0]  resultCount
);

    // mapper to bank
    logic                  binValid;
    logic [binBits-1:0]    binIdx;
    // scanner read port
    logic                  rdEn;
    logic [binBits-1:0]    rdIdx;
    logic [countWidth-1:0] rdCount;
    // scanner to tracker
    logic                  peakValid;
    logic [binBits-1:0]    peakBin;
    logic [countWidth-1:0] peakCount;

    binMapper #(
        .sampleWidth(sampleWidth),
        .binBits(binBits)
    ) binMapperU0 (
        .clk(clk),
        .arstN(arstN),
        .sampleValid(sampleValid),
        .sample(sample),
        .fineMode(fineMode),
        .windowLow(windowLow),
        .busy(busy),
        .binValid(binValid),
        .binIdx(binIdx)
    );

    histogramBank #(
        .binBits(binBits),
        .countWidth(countWidth)
    ) histogramBankU0 (
        .clk(clk),
        .arstN(arstN),
        .binValid(binValid),
        .binIdx(binIdx),
        .rdEn(rdEn),
        .rdIdx(rdIdx),
        .rdCount(rdCount)
    );

    peakScanner #(
        .binBits(binBits),
        .countWidth(countWidth)
    ) peakScannerU0 (
        .clk(clk),
        .arstN(arstN),
        .acqFinish(acqFinish),
        .rdEn(rdEn),
        .rdIdx(rdIdx),
        .rdCount(rdCount),
        .busy(busy),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    windowTracker #(
        .sampleWidth(sampleWidth),
        .binBits(binBits),
        .countWidth(countWidth)
    ) windowTrackerU0 (
        .clk(clk),
        .arstN(arstN),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .fineMode(fineMode),
        .windowLow(windowLow),
        .resultValid(resultValid),
        .resultCode(resultCode),
        .resultCount(resultCount)
    );

endmodule

/* tofHist_properties.sv */
`timescale 1ns/1ps

module tofHist_properties #(
    parameter int binBits = histPkg::binBitsDef
) (
    input logic               clk,
    input logic               arstN,
    input logic               busy,
    input logic               fineMode,
    input logic               resultValid,
    input logic               binValid,
    input logic [binBits-1:0] binIdx,
    input logic               rdEn,
    input logic [binBits-1:0] rdIdx,
    input logic               peakValid
);

    // a fine result always hands back to the coarse pass
    resultThenCoarse: assert property (@(posedge clk) disable iff (!arstN)
        resultValid |=> !fineMode)
        else $error("fineMode still high after resultValid");

    // mapper must stay quiet while the scan owns the bank
    noBinWhileBusy: assert property (@(posedge clk) disable iff (!arstN)
        $rose(binValid) |-> !busy)
        else $error("binValid rose while busy");

    // increment and read-and-clear never meet on one bin
    noBankCollision: assert property (@(posedge clk) disable iff (!arstN)
        (rdEn && binValid) |-> (rdIdx != binIdx))
        else $error("increment and read-and-clear hit the same bin");

    // 16 reads plus compare and output stages
    peakAfterBusy: assert property (@(posedge clk) disable iff (!arstN)
        $rose(busy) |-> ##17 peakValid)
        else $error("peakValid not 17 cycles after busy rose");

endmodule

bind tofHistTop tofHist_properties #(.binBits(binBits)) props0 (
    .clk(clk),
    .arstN(arstN),
    .busy(busy),
    .fineMode(fineMode),
    .resultValid(resultValid),
    .binValid(binValid),
    .binIdx(binIdx),
    .rdEn(rdEn),
    .rdIdx(rdIdx),
    .peakValid(peakValid)
);

/* vlog.f */
histPkg.sv
binMapper.sv
histogramBank.sv
peakScanner.sv
windowTracker.sv
tofHistTop.sv
tofHist_properties.sv
tofHistTb.sv

/* windowTracker.sv */
`timescale 1ns/1ps

module windowTracker #(
    parameter int sampleWidth = 10,
    parameter int binBits = 4,
    parameter int countWidth = 8
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   peakValid,
    input  logic [binBits-1:0]     peakBin,
    input  logic [countWidth-1:0]  peakCount,
    output logic                   fineMode,
    output logic [sampleWidth-1:0] windowLow,
    output logic                   resultValid,
    output logic [sampleWidth-1:0] resultCode,
    output logic [countWidth-1:0]  resultCount
);

    localparam int cShift = histPkg::coarseShift(sampleWidth, binBits);
    localparam int fShift = histPkg::fineShift(sampleWidth, binBits);
    // report the centre of the fine bin, not its lower edge
    localparam int halfBin = (1 << fShift) / 2;

    logic [sampleWidth-1:0] fineCode;

    // window start plus fine bin offset plus half a fine bin
    assign fineCode = windowLow + (sampleWidth'(peakBin) << fShift)
                    + sampleWidth'(halfBin);

    // pass FSM, coarse then fine then coarse again
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fineMode <= 1'b0;
            windowLow <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            if (peakValid) begin
                if (!fineMode) begin
                    // coarse peak picks the fine window
                    windowLow <= sampleWidth'(peakBin) << cShift;
                    fineMode <= 1'b1;
                end else begin
                    resultValid <= 1'b1;
                    fineMode <= 1'b0;
                end
            end
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (peakValid && fineMode) begin
            resultCode <= fineCode;
            resultCount <= peakCount;
        end
    end

endmodule
